// File: design/fft_tail_params.svh
`ifndef FFT_TAIL_PARAMS_SVH
`define FFT_TAIL_PARAMS_SVH

// Component widths along the pipeline
`define FFT_IN_W        16
`define FFT_A_W         18
`define FFT_B_W         20
`define FFT_OUT_W       16

// Twiddle format, 16384 is 1.0
`define FFT_TW_W        16
`define FFT_TW_SHIFT    14

// Pairs per twiddle frame
`define FFT_FRAME       8

// Commutator depths of the two stages
`define FFT_DEPTH_A     2
`define FFT_DEPTH_B     1

`endif

// File: design/fft_tail_pkg.sv
`include "fft_tail_params.svh"

package fft_tail_pkg;

        // Complex samples at each point of the pipeline
        typedef struct packed {
                logic signed [`FFT_IN_W-1:0] re;
                logic signed [`FFT_IN_W-1:0] im;
        } cplx_in_t;

        typedef struct packed {
                logic signed [`FFT_A_W-1:0] re;
                logic signed [`FFT_A_W-1:0] im;
        } cplx_a_t;

        typedef struct packed {
                logic signed [`FFT_B_W-1:0] re;
                logic signed [`FFT_B_W-1:0] im;
        } cplx_b_t;

        typedef struct packed {
                logic signed [`FFT_OUT_W-1:0] re;
                logic signed [`FFT_OUT_W-1:0] im;
        } cplx_out_t;

        typedef struct packed {
                logic signed [`FFT_TW_W-1:0] re;
                logic signed [`FFT_TW_W-1:0] im;
        } twiddle_t;

        ///////////////////////////////////////////////////////////////////////
        // W8^k = cos(pi*k/4) - j*sin(pi*k/4), scaled by 16384
        ///////////////////////////////////////////////////////////////////////
        function automatic twiddle_t twiddle_lookup(input logic [2:0] k);
                twiddle_t w;
                case (k)
                        3'd0: w = '{re:  16'sd16384, im:  16'sd0};
                        3'd1: w = '{re:  16'sd11585, im: -16'sd11585};
                        3'd2: w = '{re:  16'sd0,     im: -16'sd16384};
                        3'd3: w = '{re: -16'sd11585, im: -16'sd11585};
                        3'd4: w = '{re: -16'sd16384, im:  16'sd0};
                        3'd5: w = '{re: -16'sd11585, im:  16'sd11585};
                        3'd6: w = '{re:  16'sd0,     im:  16'sd16384};
                        default: w = '{re: 16'sd11585, im: 16'sd11585};
                endcase
                return w;
        endfunction

endpackage

// File: design/delay_commutator.sv
`timescale 1ns/100ps

module delay_commutator #(
        parameter type payload_t = logic [31:0],
        parameter int  DEPTH     = 2
) (
        input  logic     clk,
        input  logic     rst,
        input  logic     in_valid,
        input  payload_t in_up,
        input  payload_t in_down,
        output logic     out_valid,
        output payload_t out_up,
        output payload_t out_down
);

        // Group of 2*DEPTH pairs, top bit of the count is the switch
        localparam int CNT_W = $clog2(DEPTH) + 1;
        localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

        logic [CNT_W-1:0] cnt;
        logic [IDX_W-1:0] idx;
        logic             sel;
        logic             primed;

        // Two delay lines of DEPTH entries
        payload_t line_up   [DEPTH];
        payload_t line_down [DEPTH];

        assign sel = cnt[CNT_W-1];
        assign idx = IDX_W'(cnt % DEPTH);

        ///////////////////////////////////////////////////////////////////////
        // Control
        ///////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        cnt       <= '0;
                        primed    <= 1'b0;
                        out_valid <= 1'b0;
                end else begin
                        // E half only carries data once a full group was seen
                        out_valid <= in_valid & (sel | primed);
                        if (in_valid) begin
                                cnt <= cnt + 1'b1;
                                if (sel) begin
                                        primed <= 1'b1;
                                end
                        end
                end
        end

        ///////////////////////////////////////////////////////////////////////
        // Delay lines and output exchange
        ///////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        if (sel) begin
                                // O half: pair the up branch now
                                out_up       <= line_up[idx];
                                out_down     <= in_up;
                                // Slot is free, park down of O there
                                line_up[idx] <= in_down;
                        end else begin
                                // E half: drain down pairs of the last group
                                out_up         <= line_down[idx];
                                out_down       <= line_up[idx];
                                line_up[idx]   <= in_up;
                                line_down[idx] <= in_down;
                        end
                end
        end

endmodule

// File: design/twiddle_stage.sv
`timescale 1ns/100ps
`include "fft_tail_params.svh"

module twiddle_stage
        import fft_tail_pkg::*;
#(
        parameter type in_t   = cplx_in_t,
        parameter type out_t  = cplx_a_t,
        parameter int  STRIDE = 1
) (
        input  logic clk,
        input  logic rst,
        input  logic in_valid,
        input  in_t  in_up,
        input  in_t  in_down,
        output logic out_valid,
        output out_t out_up,
        output out_t out_down
);

        localparam int IN_W   = $bits(in_t) / 2;
        localparam int OUT_W  = $bits(out_t) / 2;
        localparam int PROD_W = IN_W + `FFT_TW_W + 1;
        localparam int POS_W  = $clog2(`FFT_FRAME);

        logic [POS_W-1:0]         pos;
        logic [2:0]               tw_idx;
        twiddle_t                 tw;
        logic signed [PROD_W-1:0] prod_re;
        logic signed [PROD_W-1:0] prod_im;
        logic signed [PROD_W-1:0] scaled_re;
        logic signed [PROD_W-1:0] scaled_im;

        // Position in frame times stride, mod 8
        assign tw_idx = 3'(pos * STRIDE);
        assign tw     = twiddle_lookup(tw_idx);

        // Full precision complex product
        always_comb begin
                prod_re = in_down.re * tw.re - in_down.im * tw.im;
                prod_im = in_down.re * tw.im + in_down.im * tw.re;
        end

        // Floor scaling
        assign scaled_re = prod_re >>> `FFT_TW_SHIFT;
        assign scaled_im = prod_im >>> `FFT_TW_SHIFT;

        always_ff @(posedge clk) begin
                if (rst) begin
                        pos       <= '0;
                        out_valid <= 1'b0;
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                if (pos == POS_W'(`FFT_FRAME - 1)) begin
                                        pos <= '0;
                                end else begin
                                        pos <= pos + 1'b1;
                                end
                        end
                end
        end

        // Up branch rides along in the same register
        always_ff @(posedge clk) begin
                if (in_valid) begin
                        out_up.re   <= OUT_W'(in_up.re);
                        out_up.im   <= OUT_W'(in_up.im);
                        out_down.re <= OUT_W'(scaled_re);
                        out_down.im <= OUT_W'(scaled_im);
                end
        end

endmodule

// File: design/fixed_saturator.sv
`timescale 1ns/100ps
`include "fft_tail_params.svh"

module fixed_saturator
        import fft_tail_pkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  logic      in_valid,
        input  cplx_b_t   in_up,
        input  cplx_b_t   in_down,
        output logic      out_valid,
        output cplx_out_t out_up,
        output cplx_out_t out_down
);

        // Signed limits of the output width, held at the input width
        localparam logic signed [`FFT_B_W-1:0] SAT_MAX = (1 <<< (`FFT_OUT_W - 1)) - 1;
        localparam logic signed [`FFT_B_W-1:0] SAT_MIN = -(1 <<< (`FFT_OUT_W - 1));

        function automatic logic signed [`FFT_OUT_W-1:0] clamp(
                input logic signed [`FFT_B_W-1:0] x
        );
                if (x > SAT_MAX) begin
                        return SAT_MAX[`FFT_OUT_W-1:0];
                end else if (x < SAT_MIN) begin
                        return SAT_MIN[`FFT_OUT_W-1:0];
                end else begin
                        return x[`FFT_OUT_W-1:0];
                end
        endfunction

        // Output register of the whole pipeline
        always_ff @(posedge clk) begin
                if (rst) begin
                        out_valid <= 1'b0;
                        out_up    <= '0;
                        out_down  <= '0;
                end else begin
                        out_valid <= in_valid;
                        if (in_valid) begin
                                out_up.re   <= clamp(in_up.re);
                                out_up.im   <= clamp(in_up.im);
                                out_down.re <= clamp(in_down.re);
                                out_down.im <= clamp(in_down.im);
                        end
                end
        end

endmodule

// File: design/fft_tail_top.sv
`timescale 1ns/100ps
`include "fft_tail_params.svh"

module fft_tail_top
        import fft_tail_pkg::*;
(
        input  logic      clk,
        input  logic      rst,
        input  logic      in_valid,
        input  cplx_in_t  in_up,
        input  cplx_in_t  in_down,
        output logic      out_valid,
        output cplx_out_t out_up,
        output cplx_out_t out_down
);

        // Stage A links
        logic     comm_a_valid;
        cplx_in_t comm_a_up;
        cplx_in_t comm_a_down;
        logic     tw_a_valid;
        cplx_a_t  tw_a_up;
        cplx_a_t  tw_a_down;

        // Stage B links
        logic     comm_b_valid;
        cplx_a_t  comm_b_up;
        cplx_a_t  comm_b_down;
        logic     tw_b_valid;
        cplx_b_t  tw_b_up;
        cplx_b_t  tw_b_down;

        ///////////////////////////////////////////////////////////////////////
        // Stage A, depth 2 and stride 1
        ///////////////////////////////////////////////////////////////////////
        delay_commutator #(.payload_t(cplx_in_t), .DEPTH(`FFT_DEPTH_A)) u_comm_a (
                .clk(clk), .rst(rst),
                .in_valid(in_valid), .in_up(in_up), .in_down(in_down),
                .out_valid(comm_a_valid), .out_up(comm_a_up), .out_down(comm_a_down)
        );

        twiddle_stage #(.in_t(cplx_in_t), .out_t(cplx_a_t), .STRIDE(1)) u_tw_a (
                .clk(clk), .rst(rst),
                .in_valid(comm_a_valid), .in_up(comm_a_up), .in_down(comm_a_down),
                .out_valid(tw_a_valid), .out_up(tw_a_up), .out_down(tw_a_down)
        );

        ///////////////////////////////////////////////////////////////////////
        // Stage B, depth 1 and stride 2
        ///////////////////////////////////////////////////////////////////////
        delay_commutator #(.payload_t(cplx_a_t), .DEPTH(`FFT_DEPTH_B)) u_comm_b (
                .clk(clk), .rst(rst),
                .in_valid(tw_a_valid), .in_up(tw_a_up), .in_down(tw_a_down),
                .out_valid(comm_b_valid), .out_up(comm_b_up), .out_down(comm_b_down)
        );

        twiddle_stage #(.in_t(cplx_a_t), .out_t(cplx_b_t), .STRIDE(2)) u_tw_b (
                .clk(clk), .rst(rst),
                .in_valid(comm_b_valid), .in_up(comm_b_up), .in_down(comm_b_down),
                .out_valid(tw_b_valid), .out_up(tw_b_up), .out_down(tw_b_down)
        );

        // Clamp to output width
        fixed_saturator u_sat (
                .clk(clk), .rst(rst),
                .in_valid(tw_b_valid), .in_up(tw_b_up), .in_down(tw_b_down),
                .out_valid(out_valid), .out_up(out_up), .out_down(out_down)
        );

endmodule

// File: testbench/fft_tail_checker.sv
`timescale 1ns/100ps
`include "fft_tail_params.svh"

module fft_tail_checker
        import fft_tail_pkg::*;
(
        input logic      clk,
        input logic      rst,
        input logic      in_valid,
        input cplx_in_t  in_up,
        input cplx_in_t  in_down,
        input logic      out_valid,
        input cplx_out_t out_up,
        input cplx_out_t out_down
);

        // up.re, up.im, down.re, down.im
        typedef struct {
                longint v[4];
        } pair_t;

        pair_t exp_q[$];
        pair_t pend[2][$];
        pair_t ebuf[2][2];
        int    cnt[2] = '{0, 0};
        int    pos[2] = '{0, 0};
        int    errors = 0;
        int    tests = 0;
        int    checked = 0;
        int    test_checked = 0;
        int    test_errs = 0;
        int    in_count = 0;
        int    out_count = 0;
        string test_name = "reset";

        function automatic longint wrap(input longint x, input int w);
                longint y;
                y = x <<< (64 - w);
                return y >>> (64 - w);
        endfunction

        function automatic longint clamp(input longint x);
                longint hi;
                hi = (longint'(1) <<< (`FFT_OUT_W - 1)) - 1;
                if (x > hi) return hi;
                if (x < -hi - 1) return -hi - 1;
                return x;
        endfunction

        // cos(pi*k/4) scaled by 16384
        function automatic longint cos_q(input int k);
                case (k % 8)
                        0: return 16384;
                        1, 7: return 11585;
                        2, 6: return 0;
                        3, 5: return -11585;
                        default: return -16384;
                endcase
        endfunction

        ////////////////////////////////////////////////////////////////////
        // Reference model of one commutator and one twiddle stage
        ////////////////////////////////////////////////////////////////////
        task automatic comm_step(input int s, input int depth, input pair_t p,
                                 output bit ok, output pair_t o);
                int    j;
                pair_t q;
                ok = 1'b0;
                j = cnt[s] % depth;
                if (cnt[s] < depth) begin
                        if (pend[s].size() > 0) begin
                                o = pend[s].pop_front();
                                ok = 1'b1;
                        end
                        ebuf[s][j] = p;
                end else begin
                        o.v[0] = ebuf[s][j].v[0];
                        o.v[1] = ebuf[s][j].v[1];
                        o.v[2] = p.v[0];
                        o.v[3] = p.v[1];
                        q.v[0] = ebuf[s][j].v[2];
                        q.v[1] = ebuf[s][j].v[3];
                        q.v[2] = p.v[2];
                        q.v[3] = p.v[3];
                        pend[s].push_back(q);
                        ok = 1'b1;
                end
                cnt[s] = (cnt[s] + 1) % (2 * depth);
        endtask

        task automatic tw_step(input int s, input int stride, input int w, inout pair_t p);
                int     k;
                longint wr;
                longint wi;
                longint tr;
                longint ti;
                k = (pos[s] * stride) % 8;
                wr = cos_q(k);
                wi = -cos_q(k + 6);
                tr = p.v[2] * wr - p.v[3] * wi;
                ti = p.v[2] * wi + p.v[3] * wr;
                p.v[2] = wrap(tr >>> `FFT_TW_SHIFT, w);
                p.v[3] = wrap(ti >>> `FFT_TW_SHIFT, w);
                pos[s] = (pos[s] + 1) % `FFT_FRAME;
        endtask

        task automatic report_mismatch(input pair_t p, input longint got[4]);
                $display("** Error at %0t: %s expected %0d %0d %0d %0d got %0d %0d %0d %0d",
                         $time, test_name, p.v[0], p.v[1], p.v[2], p.v[3],
                         got[0], got[1], got[2], got[3]);
        endtask

        always @(posedge clk) begin
                pair_t  p;
                pair_t  a;
                pair_t  b;
                bit     ok;
                longint got[4];
                int     bad;
                if (!rst && out_valid) begin
                        out_count++;
                        got = '{out_up.re, out_up.im, out_down.re, out_down.im};
                        if (exp_q.size() == 0) begin
                                $display("** Error at %0t: out_valid with no pair expected",
                                         $time);
                                errors++;
                                test_errs++;
                        end else begin
                                p = exp_q.pop_front();
                                bad = 0;
                                for (int i = 0; i < 4; i++) begin
                                        if (got[i] != p.v[i]) bad++;
                                end
                                checked++;
                                test_checked++;
                                if (bad != 0) begin
                                        report_mismatch(p, got);
                                        errors++;
                                        test_errs++;
                                end
                        end
                end
                if (!rst && in_valid) begin
                        in_count++;
                        p.v = '{in_up.re, in_up.im, in_down.re, in_down.im};
                        comm_step(0, `FFT_DEPTH_A, p, ok, a);
                        if (ok) begin
                                tw_step(0, 1, `FFT_A_W, a);
                                comm_step(1, `FFT_DEPTH_B, a, ok, b);
                                if (ok) begin
                                        tw_step(1, 2, `FFT_B_W, b);
                                        for (int i = 0; i < 4; i++) b.v[i] = clamp(b.v[i]);
                                        exp_q.push_back(b);
                                end
                        end
                end
        end

        ////////////////////////////////////////////////////////////////////
        // Test control called from the testbench top
        ////////////////////////////////////////////////////////////////////
        task automatic check_idle();
                for (int t = 0; t < 4; t++) begin
                        @(posedge clk);
                        if (out_valid !== 1'b0 || out_up !== '0 || out_down !== '0) begin
                                $display("** Error at %0t: outputs not idle after reset", $time);
                                errors++;
                        end
                end
        endtask

        task automatic begin_test(input string name);
                test_name = name;
                test_checked = 0;
                test_errs = 0;
        endtask

        task automatic end_test();
                int t;
                for (t = 0; t < 200 && exp_q.size() > 0; t++) @(posedge clk);
                if (exp_q.size() > 0) begin
                        $display("Timeout in test %s: out_valid never came for %0d pairs",
                                 test_name, exp_q.size());
                        errors++;
                        test_errs++;
                end
                tests++;
                $display("Test %-16s %0d pairs checked, %0d errors", test_name, test_checked,
                         test_errs);
        endtask

        task automatic final_report();
                if (out_count != in_count - (`FFT_DEPTH_A + `FFT_DEPTH_B)) begin
                        $display("** Error at %0t: %0d output pairs for %0d input pairs",
                                 $time, out_count, in_count);
                        errors++;
                end
                $display("Summary: %0d tests, %0d pairs checked, %0d errors", tests, checked,
                         errors);
        endtask

endmodule

// File: testbench/fft_tail_assertions.sv
`timescale 1ns/100ps

module fft_tail_assertions
        import fft_tail_pkg::*;
(
        input logic      clk,
        input logic      rst,
        input logic      in_valid,
        input cplx_in_t  in_up,
        input cplx_in_t  in_down,
        input logic      out_valid,
        input cplx_out_t out_up,
        input cplx_out_t out_down
);

        int fails = 0;

        // Quiet output during reset and right after it
        a_rst_quiet: assert property (@(posedge clk) rst |=> !out_valid)
                else begin
                        fails++;
                        $error("out_valid high during or just after reset");
                end
        a_rst_fall: assert property (@(posedge clk) $fell(rst) |=> !out_valid)
                else begin
                        fails++;
                        $error("out_valid high in the cycle after reset");
                end

        a_out_known: assert property (@(posedge clk) disable iff (rst)
                out_valid |-> !$isunknown({out_up, out_down}))
                else begin
                        fails++;
                        $error("unknown output data with out_valid");
                end

        // Data changes only together with its valid pulse
        a_out_hold: assert property (@(posedge clk) disable iff (rst)
                !out_valid |-> ($stable(out_up) && $stable(out_down)))
                else begin
                        fails++;
                        $error("output data changed without out_valid");
                end
        a_in_hold: assert property (@(posedge clk) disable iff (rst)
                !in_valid |-> ($stable(in_up) && $stable(in_down)))
                else begin
                        fails++;
                        $error("input data changed without in_valid");
                end

endmodule

bind fft_tail_top fft_tail_assertions u_assertions (
        .clk(clk), .rst(rst), .in_valid(in_valid), .in_up(in_up), .in_down(in_down),
        .out_valid(out_valid), .out_up(out_up), .out_down(out_down)
);

// File: testbench/fft_tail_tb.sv
`timescale 1ns/100ps

module fft_tail_tb
        import fft_tail_pkg::*;
();

        localparam logic [31:0] SEED = 32'hd89de896;
        localparam int S_FIXED = 0;
        localparam int S_SMALL = 1;
        localparam int S_FULL  = 2;

        typedef struct {
                string name;
                int    smode;
                bit    gaps;
                int    count;
        } entry_t;

        logic        clk;
        logic        rst;
        logic        in_valid;
        cplx_in_t    in_up;
        cplx_in_t    in_down;
        logic        out_valid;
        cplx_out_t   out_up;
        cplx_out_t   out_down;
        logic [31:0] data_seed;
        logic [31:0] gap_seed;
        entry_t      table_e[4];

        fft_tail_top u_fft_tail_top (
                .clk(clk), .rst(rst), .in_valid(in_valid), .in_up(in_up), .in_down(in_down),
                .out_valid(out_valid), .out_up(out_up), .out_down(out_down)
        );

        fft_tail_checker u_checker (
                .clk(clk), .rst(rst), .in_valid(in_valid), .in_up(in_up), .in_down(in_down),
                .out_valid(out_valid), .out_up(out_up), .out_down(out_down)
        );

        always #50 clk = ~clk;

        function automatic logic [31:0] lcg_next(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        task automatic make_pair(input int mode, input int i, output cplx_in_t up,
                                 output cplx_in_t dn);
                logic [15:0] r[4];
                for (int k = 0; k < 4; k++) begin
                        data_seed = lcg_next(data_seed);
                        r[k] = (mode == S_SMALL) ? {{5{data_seed[26]}}, data_seed[26:16]}
                                                 : data_seed[31:16];
                end
                up = '{re: r[0], im: r[1]};
                dn = '{re: r[2], im: r[3]};
                if (mode == S_FIXED) begin
                        // Impulse of 1.0 walks one position per frame
                        up = '{re: (i % 8 == (i / 8) % 8) ? 16'sd16384 : 16'sd0, im: '0};
                        dn = '0;
                end
        endtask

        task automatic send_pair(input cplx_in_t up, input cplx_in_t dn);
                in_valid = 1'b1;
                in_up = up;
                in_down = dn;
                @(negedge clk);
        endtask

        task automatic idle_cycle();
                in_valid = 1'b0;
                @(negedge clk);
        endtask

        initial begin
                cplx_in_t up;
                cplx_in_t dn;
                clk = 1'b0;
                rst = 1'b1;
                in_valid = 1'b0;
                in_up = '0;
                in_down = '0;
                data_seed = SEED;
                gap_seed = SEED ^ 32'h5a5a5a5a;
                table_e[0] = '{"impulse", S_FIXED, 1'b0, 64};
                table_e[1] = '{"random_small", S_SMALL, 1'b0, 64};
                table_e[2] = '{"random_gaps", S_SMALL, 1'b1, 64};
                table_e[3] = '{"full_scale", S_FULL, 1'b0, 64};

                repeat (16) @(posedge clk);
                @(negedge clk);
                rst = 1'b0;
                u_checker.check_idle();
                @(negedge clk);

                for (int t = 0; t < 4; t++) begin
                        u_checker.begin_test(table_e[t].name);
                        // Random tests share one data sequence
                        if (table_e[t].smode != S_FIXED) data_seed = SEED;
                        for (int i = 0; i < table_e[t].count; i++) begin
                                if (table_e[t].gaps) begin
                                        gap_seed = lcg_next(gap_seed);
                                        repeat (gap_seed[31:30]) idle_cycle();
                                end
                                make_pair(table_e[t].smode, i, up, dn);
                                send_pair(up, dn);
                        end
                        // Flush pairs push the held data out
                        repeat (8) send_pair('0, '0);
                        idle_cycle();
                        u_checker.end_test();
                        @(negedge clk);
                end

                u_checker.final_report();
                if (u_checker.errors == 0 && u_fft_tail_top.u_assertions.fails == 0) begin
                        $display("ALL CHECKS PASSED");
                end else begin
                        $display("CHECKS FAILED");
                end
                $finish;
        end

endmodule

// File: build.f
+incdir+design
design/fft_tail_pkg.sv
design/delay_commutator.sv
design/twiddle_stage.sv
design/fixed_saturator.sv
design/fft_tail_top.sv
testbench/fft_tail_checker.sv
testbench/fft_tail_assertions.sv
testbench/fft_tail_tb.sv

// File: Makefile
.PHONY: all compile run check clean

all: check

compile:
	verilator --binary --timing --assert -Wno-fatal -f build.f \
		--top-module fft_tail_tb -Mdir obj_dir -o fft_tail_sim

run: compile
	./obj_dir/fft_tail_sim | tee sim.log

check: run
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
